// File: rtl/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define EXCEPT_W    15
`define FETCH_EXC_W 2

// Immediate widths per issue queue
`define ALU0_IMM_W  20      // 12-bit field or LU12I si20
`define AGU_IMM_W   14
`define BRU_IMM_W   26      // offs26 or PCADDU12I si20

// Boot vector
`define RESET_PC    32'h1c00_0000

`endif

// File: rtl/decode_pkg.sv
`include "decode_config.svh"

package decode_pkg;

    typedef logic [3:0] iq_sel_t;           // One-hot, zero means no queue

    localparam iq_sel_t IQ_NONE = 4'b0000;
    localparam iq_sel_t IQ_BRU  = 4'b0001;
    localparam iq_sel_t IQ_AGU  = 4'b0010;
    localparam iq_sel_t IQ_ALU1 = 4'b0100;
    localparam iq_sel_t IQ_ALU0 = 4'b1000;

    typedef enum logic [4:0] {
        ALU0_LU12I  = 5'd0,  ALU0_SLTI   = 5'd1,  ALU0_SLTUI  = 5'd2,
        ALU0_ADDI_W = 5'd3,  ALU0_ANDI   = 5'd4,  ALU0_ORI    = 5'd5,
        ALU0_XORI   = 5'd6,  ALU0_ADD_W  = 5'd7,  ALU0_SUB_W  = 5'd8,
        ALU0_SLT    = 5'd9,  ALU0_SLTU   = 5'd10, ALU0_NOR    = 5'd11,
        ALU0_AND    = 5'd12, ALU0_OR     = 5'd13, ALU0_XOR    = 5'd14,
        ALU0_SLL_W  = 5'd15, ALU0_SRL_W  = 5'd16, ALU0_SRA_W  = 5'd17,
        ALU0_SLLI_W = 5'd21, ALU0_SRLI_W = 5'd22, ALU0_SRAI_W = 5'd23
    } alu0_op_t;

    typedef enum logic [2:0] {
        ALU1_DIV_W  = 3'd0, ALU1_MOD_W  = 3'd1, ALU1_DIVU_W   = 3'd2,
        ALU1_MODU_W = 3'd3, ALU1_MUL_W  = 3'd4, ALU1_MULH_W   = 3'd5,
        ALU1_MULHU_W = 3'd6
    } alu1_op_t;

    typedef enum logic [3:0] {
        AGU_NONE = 4'd0,                    // No memory op
        AGU_LD_B = 4'd7,  AGU_LD_H = 4'd8,  AGU_LD_W  = 4'd9,
        AGU_ST_B = 4'd10, AGU_ST_H = 4'd11, AGU_ST_W  = 4'd12,
        AGU_LD_BU = 4'd13, AGU_LD_HU = 4'd14
    } agu_op_t;

    typedef enum logic [3:0] {
        BRU_PCADDU12I = 4'd0, BRU_JIRL = 4'd1, BRU_B    = 4'd2, BRU_BL   = 4'd3,
        BRU_BEQ       = 4'd4, BRU_BNE  = 4'd5, BRU_BLT  = 4'd6, BRU_BGE  = 4'd7,
        BRU_BLTU      = 4'd8, BRU_BGEU = 4'd9
    } bru_op_t;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] idx;
    } reg_field_t;

    typedef struct packed {
        iq_sel_t                iq_choose;
        alu0_op_t               alu0_op;
        alu1_op_t               alu1_op;
        agu_op_t                agu_op;
        bru_op_t                bru_op;
        logic [`ALU0_IMM_W-1:0] alu0_imm;
        logic [`AGU_IMM_W-1:0]  agu_imm;
        logic [`BRU_IMM_W-1:0]  bru_imm;
        reg_field_t             dest;
        reg_field_t             src1;
        reg_field_t             src2;
        logic [`EXCEPT_W-1:0]   except_code;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       target;     // Predicted target
    } decoded_uop_t;

endpackage

// File: rtl/decoded_uop_if.sv
`timescale 1ns/1ps
`include "decode_config.svh"

interface decoded_uop_if;

    logic                     valid;
    logic                     ready;
    decode_pkg::decoded_uop_t uop;

    modport producer (
        output valid,
        output uop,
        input  ready
    );

    modport consumer (
        input  valid,
        input  uop,
        output ready
    );

endinterface

// File: rtl/instr_classify.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module instr_classify (
    input  logic [`XLEN-1:0]        instruction,
    input  logic [`FETCH_EXC_W-1:0] fetch_except,
    output decode_pkg::iq_sel_t     iq_choose,
    output logic [`EXCEPT_W-1:0]    except_code,
    output logic                    trap
);

    logic is_break;
    logic is_syscall;

    assign is_break   = (instruction[31:15] == 17'b00000000001010100);
    assign is_syscall = (instruction[31:15] == 17'b00000000001010110);
    assign trap       = is_break || is_syscall;

    always_comb begin
        iq_choose = decode_pkg::IQ_NONE;
        if (instruction[30]) begin
            if (instruction[29:26] inside {[4'b0011:4'b1011]})     // JIRL up to BGEU
                iq_choose = decode_pkg::IQ_BRU;
        end else begin
            case (instruction[29:28])
                2'b10: begin
                    if (instruction[27:26] == 2'b10 &&
                        instruction[25:22] inside {4'b0000, 4'b0001, 4'b0010, 4'b0100,
                                                   4'b0101, 4'b0110, 4'b1000, 4'b1001})
                        iq_choose = decode_pkg::IQ_AGU;
                end
                2'b01: iq_choose = instruction[27] ? decode_pkg::IQ_BRU : decode_pkg::IQ_ALU0;
                2'b00: begin
                    if (instruction[27:25] == 3'b001) begin             // 2RI12 forms
                        if (instruction[24:22] != 3'b011 && instruction[24:22] != 3'b100)
                            iq_choose = decode_pkg::IQ_ALU0;
                    end else if (instruction[27:22] == 6'b000001) begin // Shift by imm
                        if (instruction[21:20] == 2'b00 && instruction[17:15] == 3'b001 &&
                            instruction[19:18] != 2'b11)
                            iq_choose = decode_pkg::IQ_ALU0;
                    end else if (instruction[27:22] == 6'b000000) begin
                        case (instruction[21:15])
                            7'b0100000, 7'b0100010, 7'b0100100, 7'b0100101,
                            7'b0101000, 7'b0101001, 7'b0101010, 7'b0101011,
                            7'b0101110, 7'b0101111, 7'b0110000:
                                iq_choose = decode_pkg::IQ_ALU0;
                            7'b0111000, 7'b0111001, 7'b0111010,
                            7'b1000000, 7'b1000001, 7'b1000010, 7'b1000011:
                                iq_choose = decode_pkg::IQ_ALU1;  // Mul and div
                            default: iq_choose = decode_pkg::IQ_NONE;
                        endcase
                    end
                end
                default: iq_choose = decode_pkg::IQ_NONE;
            endcase
        end
    end

    // Fetch faults win over the trap code field
    always_comb begin
        if (|fetch_except)
            except_code = `EXCEPT_W'(fetch_except);
        else if (trap)
            except_code = instruction[14:0];
        else
            except_code = '0;
    end

endmodule

// File: rtl/op_decode.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module op_decode (
    input  logic [`XLEN-1:0]    instruction,
    input  decode_pkg::iq_sel_t iq_choose,
    decoded_uop_if.producer     uop_bus
);

    decode_pkg::alu0_op_t   alu0_op;
    decode_pkg::alu1_op_t   alu1_op;
    decode_pkg::agu_op_t    agu_op;
    decode_pkg::bru_op_t    bru_op;
    decode_pkg::reg_field_t dest;
    decode_pkg::reg_field_t src1;
    decode_pkg::reg_field_t src2;
    logic [`ALU0_IMM_W-1:0] alu0_imm;
    logic [`AGU_IMM_W-1:0]  agu_imm;
    logic [`BRU_IMM_W-1:0]  bru_imm;
    logic                   sel_alu0;
    logic                   sel_alu1;
    logic                   sel_agu;
    logic                   sel_bru;
    logic                   is_store;
    logic                   is_3r;

    assign sel_alu0 = (iq_choose == decode_pkg::IQ_ALU0);
    assign sel_alu1 = (iq_choose == decode_pkg::IQ_ALU1);
    assign sel_agu  = (iq_choose == decode_pkg::IQ_AGU);
    assign sel_bru  = (iq_choose == decode_pkg::IQ_BRU);
    assign is_store = sel_agu && instruction[24];
    assign is_3r    = sel_alu1 || (sel_alu0 && instruction[28:22] == 7'd0);

    always_comb begin
        alu0_op = decode_pkg::ALU0_LU12I;
        if (sel_alu0 && !instruction[28]) begin
            if (instruction[25]) begin
                case (instruction[24:22])
                    3'b000:  alu0_op = decode_pkg::ALU0_SLTI;
                    3'b001:  alu0_op = decode_pkg::ALU0_SLTUI;
                    3'b010:  alu0_op = decode_pkg::ALU0_ADDI_W;
                    3'b101:  alu0_op = decode_pkg::ALU0_ANDI;
                    3'b110:  alu0_op = decode_pkg::ALU0_ORI;
                    default: alu0_op = decode_pkg::ALU0_XORI;
                endcase
            end else if (instruction[22]) begin
                case (instruction[19:18])
                    2'b00:   alu0_op = decode_pkg::ALU0_SLLI_W;
                    2'b01:   alu0_op = decode_pkg::ALU0_SRLI_W;
                    default: alu0_op = decode_pkg::ALU0_SRAI_W;
                endcase
            end else begin
                case (instruction[19:15])
                    5'b00000: alu0_op = decode_pkg::ALU0_ADD_W;
                    5'b00010: alu0_op = decode_pkg::ALU0_SUB_W;
                    5'b00100: alu0_op = decode_pkg::ALU0_SLT;
                    5'b00101: alu0_op = decode_pkg::ALU0_SLTU;
                    5'b01000: alu0_op = decode_pkg::ALU0_NOR;
                    5'b01001: alu0_op = decode_pkg::ALU0_AND;
                    5'b01010: alu0_op = decode_pkg::ALU0_OR;
                    5'b01011: alu0_op = decode_pkg::ALU0_XOR;
                    5'b01110: alu0_op = decode_pkg::ALU0_SLL_W;
                    5'b01111: alu0_op = decode_pkg::ALU0_SRL_W;
                    default:  alu0_op = decode_pkg::ALU0_SRA_W;
                endcase
            end
        end
    end

    always_comb begin
        alu1_op = decode_pkg::ALU1_DIV_W;
        if (sel_alu1) begin
            if (instruction[21]) begin
                case (instruction[16:15])
                    2'b00:   alu1_op = decode_pkg::ALU1_DIV_W;
                    2'b01:   alu1_op = decode_pkg::ALU1_MOD_W;
                    2'b10:   alu1_op = decode_pkg::ALU1_DIVU_W;
                    default: alu1_op = decode_pkg::ALU1_MODU_W;
                endcase
            end else begin
                case (instruction[16:15])
                    2'b00:   alu1_op = decode_pkg::ALU1_MUL_W;
                    2'b01:   alu1_op = decode_pkg::ALU1_MULH_W;
                    default: alu1_op = decode_pkg::ALU1_MULHU_W;
                endcase
            end
        end
    end

    always_comb begin
        agu_op = decode_pkg::AGU_NONE;
        if (sel_agu) begin
            case (instruction[25:22])
                4'b0000: agu_op = decode_pkg::AGU_LD_B;
                4'b0001: agu_op = decode_pkg::AGU_LD_H;
                4'b0010: agu_op = decode_pkg::AGU_LD_W;
                4'b0100: agu_op = decode_pkg::AGU_ST_B;
                4'b0101: agu_op = decode_pkg::AGU_ST_H;
                4'b0110: agu_op = decode_pkg::AGU_ST_W;
                4'b1000: agu_op = decode_pkg::AGU_LD_BU;
                4'b1001: agu_op = decode_pkg::AGU_LD_HU;
                default: agu_op = decode_pkg::AGU_NONE;
            endcase
        end
    end

    always_comb begin
        bru_op = decode_pkg::BRU_PCADDU12I;
        if (sel_bru && instruction[30]) begin
            case (instruction[29:26])
                4'b0011: bru_op = decode_pkg::BRU_JIRL;
                4'b0100: bru_op = decode_pkg::BRU_B;
                4'b0101: bru_op = decode_pkg::BRU_BL;
                4'b0110: bru_op = decode_pkg::BRU_BEQ;
                4'b0111: bru_op = decode_pkg::BRU_BNE;
                4'b1000: bru_op = decode_pkg::BRU_BLT;
                4'b1001: bru_op = decode_pkg::BRU_BGE;
                4'b1010: bru_op = decode_pkg::BRU_BLTU;
                default: bru_op = decode_pkg::BRU_BGEU;
            endcase
        end
    end

    assign alu0_imm = !sel_alu0      ? '0 :
                      instruction[28] ? instruction[24:5] : `ALU0_IMM_W'(instruction[21:10]);
    assign agu_imm  = sel_agu ? instruction[23:10] : '0;

    always_comb begin
        bru_imm = '0;
        if (sel_bru) begin
            if (!instruction[30])
                bru_imm = `BRU_IMM_W'(instruction[24:5]);
            else if (instruction[29:27] == 3'b010)
                bru_imm = {instruction[9:0], instruction[25:10]};  // B and BL offs26
            else
                bru_imm = `BRU_IMM_W'(instruction[25:10]);
        end
    end

    always_comb begin
        dest = '0;
        src1 = '0;
        src2 = '0;
        if (sel_alu0 || sel_alu1 || (sel_agu && !is_store) ||
            (sel_bru && bru_op inside {decode_pkg::BRU_PCADDU12I, decode_pkg::BRU_JIRL})) begin
            dest.en  = 1'b1;
            dest.idx = instruction[4:0];
        end else if (sel_bru && bru_op == decode_pkg::BRU_BL) begin
            dest.en  = 1'b1;
            dest.idx = `REG_ADDR_W'(1);                            // Link register
        end
        if ((|iq_choose) && !(sel_alu0 && instruction[28]) &&
            !(sel_bru && bru_op inside {decode_pkg::BRU_PCADDU12I, decode_pkg::BRU_B,
                                        decode_pkg::BRU_BL})) begin
            src1.en  = 1'b1;
            src1.idx = instruction[9:5];
        end
        if (is_3r) begin
            src2.en  = 1'b1;
            src2.idx = instruction[14:10];
        end else if (is_store ||
                     (sel_bru && bru_op inside {[decode_pkg::BRU_BEQ:decode_pkg::BRU_BGEU]})) begin
            src2.en  = 1'b1;
            src2.idx = instruction[4:0];                           // rd read as data
        end
    end

    assign uop_bus.uop.alu0_op  = alu0_op;
    assign uop_bus.uop.alu1_op  = alu1_op;
    assign uop_bus.uop.agu_op   = agu_op;
    assign uop_bus.uop.bru_op   = bru_op;
    assign uop_bus.uop.alu0_imm = alu0_imm;
    assign uop_bus.uop.agu_imm  = agu_imm;
    assign uop_bus.uop.bru_imm  = bru_imm;
    assign uop_bus.uop.dest     = dest;
    assign uop_bus.uop.src1     = src1;
    assign uop_bus.uop.src2     = src2;

endmodule

// File: rtl/stage3_reg.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module stage3_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      keep,
    decoded_uop_if.consumer           uop_in,
    output logic                      decode_vld,
    input  logic                      out_ready,
    output decode_pkg::decoded_uop_t  uop_q
);

    logic load;

    assign uop_in.ready = !decode_vld || out_ready;        // Empty or draining
    assign load         = uop_in.valid && uop_in.ready && keep && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush)
            decode_vld <= 1'b0;
        else if (load)
            decode_vld <= 1'b1;
        else if (out_ready)
            decode_vld <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst)
            uop_q.pc <= `RESET_PC;                             // Boot vector until first load
        else if (load)
            uop_q <= uop_in.uop;
    end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        instruction_vld,
    output logic                        in_ready,
    input  logic [`XLEN-1:0]            instruction,
    input  logic [`XLEN-1:0]            pc,
    input  logic [`XLEN-1:0]            target,
    input  logic [`FETCH_EXC_W-1:0]     fetch_except,
    input  logic                        out_ready,
    output logic                        decode_vld,
    output decode_pkg::iq_sel_t         iq_choose,
    output decode_pkg::alu0_op_t        alu0_op,
    output decode_pkg::alu1_op_t        alu1_op,
    output decode_pkg::agu_op_t         agu_op,
    output decode_pkg::bru_op_t         bru_op,
    output logic [`ALU0_IMM_W-1:0]      alu0_imm,
    output logic [`AGU_IMM_W-1:0]       agu_imm,
    output logic [`BRU_IMM_W-1:0]       bru_imm,
    output logic                        dest_en,
    output logic [`REG_ADDR_W-1:0]      dest_reg,
    output logic                        src1_en,
    output logic [`REG_ADDR_W-1:0]      src1_reg,
    output logic                        src2_en,
    output logic [`REG_ADDR_W-1:0]      src2_reg,
    output logic [`EXCEPT_W-1:0]        except_code,
    output logic [`XLEN-1:0]            pc_q,
    output logic [`XLEN-1:0]            target_q
);

    decode_pkg::iq_sel_t      iq_sel;
    decode_pkg::decoded_uop_t uop_q;
    logic [`EXCEPT_W-1:0]     exc_code;
    logic                     trap;
    logic                     keep;

    decoded_uop_if uop_bus ();

    instr_classify instr_classify_i (
        .instruction  (instruction),
        .fetch_except (fetch_except),
        .iq_choose    (iq_sel),
        .except_code  (exc_code),
        .trap         (trap)
    );

    op_decode op_decode_i (
        .instruction (instruction),
        .iq_choose   (iq_sel),
        .uop_bus     (uop_bus)
    );

    // Unissued, trap-free, fault-free words are accepted and dropped
    assign keep = (|iq_sel) || trap || (|exc_code);

    assign uop_bus.valid           = instruction_vld;
    assign uop_bus.uop.iq_choose   = iq_sel;
    assign uop_bus.uop.except_code = exc_code;
    assign uop_bus.uop.pc          = pc;
    assign uop_bus.uop.target      = target;
    assign in_ready                = uop_bus.ready;

    stage3_reg stage3_reg_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .keep       (keep),
        .uop_in     (uop_bus),
        .decode_vld (decode_vld),
        .out_ready  (out_ready),
        .uop_q      (uop_q)
    );

    assign iq_choose   = uop_q.iq_choose;
    assign alu0_op     = uop_q.alu0_op;
    assign alu1_op     = uop_q.alu1_op;
    assign agu_op      = uop_q.agu_op;
    assign bru_op      = uop_q.bru_op;
    assign alu0_imm    = uop_q.alu0_imm;
    assign agu_imm     = uop_q.agu_imm;
    assign bru_imm     = uop_q.bru_imm;
    assign dest_en     = uop_q.dest.en;
    assign dest_reg    = uop_q.dest.idx;
    assign src1_en     = uop_q.src1.en;
    assign src1_reg    = uop_q.src1.idx;
    assign src2_en     = uop_q.src2.en;
    assign src2_reg    = uop_q.src2.idx;
    assign except_code = uop_q.except_code;
    assign pc_q        = uop_q.pc;
    assign target_q    = uop_q.target;

endmodule

// File: verification/tb_decode_stage.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module tb_decode_stage;

    logic                     clk;
    logic                     rst;
    logic                     flush;
    logic                     instruction_vld;
    logic                     in_ready;
    logic [`XLEN-1:0]         instruction;
    logic [`XLEN-1:0]         pc;
    logic [`XLEN-1:0]         target;
    logic [`FETCH_EXC_W-1:0]  fetch_except;
    logic                     out_ready;
    logic                     decode_vld;
    decode_pkg::iq_sel_t      iq_choose;
    decode_pkg::alu0_op_t     alu0_op;
    decode_pkg::alu1_op_t     alu1_op;
    decode_pkg::agu_op_t      agu_op;
    decode_pkg::bru_op_t      bru_op;
    logic [`ALU0_IMM_W-1:0]   alu0_imm;
    logic [`AGU_IMM_W-1:0]    agu_imm;
    logic [`BRU_IMM_W-1:0]    bru_imm;
    logic                     dest_en;
    logic [`REG_ADDR_W-1:0]   dest_reg;
    logic                     src1_en;
    logic [`REG_ADDR_W-1:0]   src1_reg;
    logic                     src2_en;
    logic [`REG_ADDR_W-1:0]   src2_reg;
    logic [`EXCEPT_W-1:0]     except_code;
    logic [`XLEN-1:0]         pc_q;
    logic [`XLEN-1:0]         target_q;

    logic [31:0]  vec[64][14];   // Columns as in the vector file header
    int           nvec;
    int           exp_q[$];
    int           errors;
    int           cycles;
    int           limit;
    logic         rand_en;
    logic         held_flag;
    logic [176:0] held_val;

    decode_stage decode_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout reached after %0d cycles, DUT stopped responding", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Random back-pressure on the output side
    always @(posedge clk) begin
        #1;
        if (rand_en)
            out_ready = ($urandom % 3) != 0;
    end

    task automatic check_field(input int k, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("[FAIL] %0t ns: vector %0d %s got %h expected %h", $time, k, name,
                     got, exp);
            errors++;
        end
    endtask

    function automatic logic [176:0] output_snapshot();
        return {iq_choose, alu0_op, alu1_op, agu_op, bru_op, alu0_imm, agu_imm, bru_imm,
                dest_en, dest_reg, src1_en, src1_reg, src2_en, src2_reg, except_code,
                pc_q, target_q};
    endfunction

    // Op codes of unselected queues read zero
    task automatic check_output(input int k);
        logic [31:0] iq;
        iq = vec[k][4];
        check_field(k, "iq_choose", 32'(iq_choose), iq);
        check_field(k, "alu0_op", 32'(alu0_op), (iq == 32'h8) ? vec[k][5] : 32'h0);
        check_field(k, "alu1_op", 32'(alu1_op), (iq == 32'h4) ? vec[k][5] : 32'h0);
        check_field(k, "agu_op", 32'(agu_op), (iq == 32'h2) ? vec[k][5] : 32'h0);
        check_field(k, "bru_op", 32'(bru_op), (iq == 32'h1) ? vec[k][5] : 32'h0);
        case (iq)
            32'h8:   check_field(k, "alu0_imm", 32'(alu0_imm), vec[k][6]);
            32'h2:   check_field(k, "agu_imm", 32'(agu_imm), vec[k][6]);
            32'h1:   check_field(k, "bru_imm", 32'(bru_imm), vec[k][6]);
            default: ;                                   // ALU1 and no queue carry no immediate
        endcase
        check_field(k, "dest_en", 32'(dest_en), vec[k][7]);
        check_field(k, "dest_reg", 32'(dest_reg), vec[k][8]);
        check_field(k, "src1_en", 32'(src1_en), vec[k][9]);
        check_field(k, "src1_reg", 32'(src1_reg), vec[k][10]);
        check_field(k, "src2_en", 32'(src2_en), vec[k][11]);
        check_field(k, "src2_reg", 32'(src2_reg), vec[k][12]);
        check_field(k, "except_code", 32'(except_code), vec[k][13]);
        check_field(k, "pc_q", pc_q, vec[k][1]);
        check_field(k, "target_q", target_q, vec[k][1] + 32'h40);
    endtask

    // Sample mid-cycle for the transfer on the next rising edge
    always @(negedge clk) begin
        if (held_flag && decode_vld) begin
            assert (output_snapshot() == held_val) else begin
                $display("[FAIL] %0t ns: output changed while stalled", $time);
                errors++;
            end
        end
        held_flag = decode_vld && !out_ready;
        held_val  = output_snapshot();
        if (decode_vld && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected output at %0t ns with nothing expected", $time);
                errors++;
            end else begin
                check_output(exp_q.pop_front());
            end
        end
    end

    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] t[14];
        nvec = 0;
        fd = $fopen("verification/decode_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            errors++;
        end else begin
            while (!$feof(fd) && nvec < 64) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 8 && line.substr(0, 0) != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7],
                                  t[8], t[9], t[10], t[11], t[12], t[13]);
                    if (cnt == 14) begin
                        vec[nvec] = t;
                        nvec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive(input int k, input logic vld);
        instruction_vld = vld;
        instruction     = vec[k][0];
        pc              = vec[k][1];
        target          = vec[k][1] + 32'h40;
        fetch_except    = vec[k][2][`FETCH_EXC_W-1:0];
    endtask

    // Holds the vector until accepted and returns 1 ns after that edge
    task automatic send_vector(input int k);
        logic accepted;
        accepted = 1'b0;
        drive(k, 1'b1);
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
            #1;
        end
        if (vec[k][3] != 0)
            exp_q.push_back(k);
        instruction_vld = 1'b0;
    endtask

    initial begin
        int base;
        int waited;
        void'($urandom(14));
        errors          = 0;
        cycles          = 0;
        limit           = 0;
        rand_en         = 1'b0;
        held_flag       = 1'b0;
        held_val        = '0;
        rst             = 1'b1;
        flush           = 1'b0;
        out_ready       = 1'b0;
        instruction_vld = 1'b0;
        instruction     = '0;
        pc              = '0;
        target          = '0;
        fetch_except    = '0;
        load_vectors();
        limit = 10 * nvec + 100;

        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        assert (!decode_vld && in_ready && pc_q == `RESET_PC) else begin
            $display("[FAIL] %0t ns: state after reset vld=%b ready=%b pc=%h", $time,
                     decode_vld, in_ready, pc_q);
            errors++;
        end
        $display("reset check finished, %0d errors", errors);

        base = errors;
        rand_en = 1'b1;
        @(posedge clk);
        #1;
        for (int k = 0; k < nvec; k++)
            send_vector(k);
        waited = 0;
        while (exp_q.size() != 0 && waited < 4 * nvec) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Missing outputs, %0d expected results never appeared", exp_q.size());
            errors++;
        end
        rand_en = 1'b0;
        @(posedge clk);
        #1 out_ready = 1'b0;
        $display("stream check of %0d vectors finished, %0d errors", nvec, errors - base);

        base = errors;
        send_vector(0);                                  // Parked in the stage register
        flush = 1'b1;
        @(posedge clk);
        #1 flush = 1'b0;
        exp_q.delete();
        @(negedge clk);
        assert (!decode_vld) else begin
            $display("[FAIL] %0t ns: flush left the held instruction valid", $time);
            errors++;
        end
        @(posedge clk);
        #1;
        drive(1, 1'b1);                                  // Accepted during flush
        flush = 1'b1;
        @(posedge clk);
        #1 flush = 1'b0;
        instruction_vld = 1'b0;
        repeat (2) @(negedge clk);
        assert (!decode_vld) else begin
            $display("[FAIL] %0t ns: input taken during flush reached the output", $time);
            errors++;
        end
        $display("flush check finished, %0d errors", errors - base);

        $display("Checks done: %0d vectors, %0d errors", nvec, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: verification/decode_vectors.txt
# instr pc fetch_exc keep iq op imm dest_en dest src1_en src1 src2_en src2 except_code
# all hex; op and imm belong to the selected queue, zero when none
001018a4 1c000000 0 1 8 07 00406 1 04 1 05 1 06 0000
03848d07 1c000004 0 1 8 05 00123 1 07 1 08 0 00 0000
00488d49 1c000008 0 1 8 17 00223 1 09 1 0a 0 00 0000
142468ab 1c00000c 0 1 8 00 12345 1 0b 0 00 0 00 0000
001c39ac 1c000010 0 1 4 04 00000 1 0c 1 0d 1 0e 0000
0021c60f 1c000014 0 1 4 03 00000 1 0f 1 10 1 11 0000
2a5fc272 1c000018 0 1 2 0e 017f0 1 12 1 13 0 00 0000
298022b4 1c00001c 0 1 2 0c 02008 0 00 1 15 1 14 0000
580042d7 1c000020 0 1 1 04 00010 0 00 1 16 1 17 0000
548d1401 1c000024 0 1 1 03 12345 1 01 0 00 0 00 0000
4c010301 1c000028 0 1 1 01 00040 1 01 1 18 0 00 0000
1c015799 1c00002c 0 1 1 00 00abc 1 19 0 00 0 00 0000
002b0055 1c000030 0 1 0 00 00000 0 00 0 00 0 00 0055
002a0007 1c000034 2 1 0 00 00000 0 00 0 00 0 00 0002
04000004 1c000038 0 0 0 00 00000 0 00 0 00 0 00 0000
06483800 1c00003c 0 0 0 00 00000 0 00 0 00 0 00 0000
02bffc41 1c000040 3 1 8 03 00fff 1 01 1 02 0 00 0003
00110c41 1c000044 0 1 8 08 00443 1 01 1 02 1 03 0000
50040003 1c000048 0 1 1 02 30100 0 00 0 00 0 00 0000
5c008085 1c00004c 0 1 1 05 00020 0 00 1 04 1 05 0000
288010e6 1c000050 0 1 2 09 02004 1 06 1 07 0 00 0000
00200c41 1c000054 0 1 4 00 00000 1 01 1 02 1 03 0000
02600062 1c000058 0 1 8 02 00800 1 02 1 03 0 00 0000
04000004 1c00005c 1 1 0 00 00000 0 00 0 00 0 00 0001

// File: list.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/decoded_uop_if.sv
rtl/instr_classify.sv
rtl/op_decode.sv
rtl/stage3_reg.sv
rtl/decode_stage.sv
verification/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_decode_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_decode_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASS$"; then
    exit 0
fi
exit 1
